// File: include/chan_select_cfg.svh
/*
 * channel selector configuration
 * channel counts, sample width and Wishbone data width
 */
`ifndef CHAN_SELECT_CFG_SVH
`define CHAN_SELECT_CFG_SVH

// physical ADC channels coming in
`define PHYS_CHANNELS 4

// logical channels going out
`define OUT_CHANNELS 4

// signed two's complement samples
`define SAMPLE_WIDTH 16

// Wishbone data bus
`define WB_DATA_WIDTH 32

// raw, derivative and average groups
`define SOURCE_COUNT (3 * `PHYS_CHANNELS)

`endif

// File: verilog/chan_select_pkg.sv
/*
 * channel selector types
 * sample word, source index and the two views of a Wishbone config word
 */
`include "chan_select_cfg.svh"

package chan_select_pkg;

  // one signed ADC sample
  typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

  // source index, enough for 12 sources plus a zero range
  // 0-3 raw, 4-7 derivative, 8-11 average, 12-15 zero with valid low
  typedef logic [3:0] source_sel_t;

  // select word at address 0
  // output 0 sits in the low nibble
  typedef struct packed {
    logic [`WB_DATA_WIDTH-4*`OUT_CHANNELS-1:0] pad;
    source_sel_t [`OUT_CHANNELS-1:0]           sel;
  } sel_view_t;

  // control word at address 1
  typedef struct packed {
    logic [`WB_DATA_WIDTH-4:0] pad;
    logic                      avg_four_tap;
    logic [1:0]                diff_shift;
  } ctrl_view_t;

  // one bus word, decoded by address
  typedef union packed {
    sel_view_t  sel_view;
    ctrl_view_t ctrl_view;
  } cfg_word_u;

endpackage

// File: verilog/wb_select_regs.sv
/*
 * channel selector register block
 * Wishbone classic slave with one-cycle ack, holds the source map
 * and the derivative / filter controls, with readback
 */
`include "chan_select_cfg.svh"

module wb_select_regs (
  input  logic                                    data_clk,
  input  logic                                    data_reset,
  input  logic                                    wb_cyc,
  input  logic                                    wb_stb,
  input  logic                                    wb_we,
  input  logic                                    wb_adr,
  input  logic [`WB_DATA_WIDTH-1:0]               wb_dat_w,
  output logic [`WB_DATA_WIDTH-1:0]               wb_dat_r,
  output logic                                    wb_ack,
  output chan_select_pkg::source_sel_t [`OUT_CHANNELS-1:0] select_map,
  output logic [1:0]                              diff_shift,
  output logic                                    avg_four_tap
);

  import chan_select_pkg::*;

  // word addresses
  localparam logic ADR_SELECT  = 1'b0;
  localparam logic ADR_CONTROL = 1'b1;

  cfg_word_u wr_word;
  cfg_word_u rd_word;
  logic      xfer_start;
  // set once a transfer is acked, cleared when stb goes low
  logic      busy;

  // incoming word, decoded through whichever view the address picks
  assign wr_word = wb_dat_w;

  // new cycle only after stb has dropped since the last ack
  assign xfer_start = wb_cyc && wb_stb && !busy;

  // readback with zero padding
  always_comb begin
    rd_word = '0;
    if (wb_adr == ADR_CONTROL) begin
      rd_word.ctrl_view.diff_shift   = diff_shift;
      rd_word.ctrl_view.avg_four_tap = avg_four_tap;
    end else begin
      rd_word.sel_view.sel = select_map;
    end
  end

  // ack handshake
  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      wb_ack <= 1'b0;
      busy   <= 1'b0;
    end else begin
      wb_ack <= xfer_start;
      if (xfer_start) begin
        busy <= 1'b1;
      end else if (!wb_stb) begin
        busy <= 1'b0;
      end
    end
  end

  // config registers, written on the edge that raises ack
  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      // identity map, output k takes raw channel k
      for (int k = 0; k < `OUT_CHANNELS; k++) begin
        select_map[k] <= source_sel_t'(k);
      end
      diff_shift   <= 2'd0;
      avg_four_tap <= 1'b0;
    end else if (xfer_start && wb_we) begin
      if (wb_adr == ADR_SELECT) begin
        select_map <= wr_word.sel_view.sel;
      end else begin
        diff_shift   <= wr_word.ctrl_view.diff_shift;
        avg_four_tap <= wr_word.ctrl_view.avg_four_tap;
      end
    end
  end

  // read data held for the ack cycle
  always_ff @(posedge data_clk) begin
    if (xfer_start && !wb_we) begin
      wb_dat_r <= rd_word;
    end
  end

endmodule

// File: verilog/finite_diff.sv
/*
 * finite-difference derivative
 * current minus previous valid sample per channel, shifted left
 * by a programmable amount and saturated to the sample range
 */
`include "chan_select_cfg.svh"

module finite_diff (
  input  logic                                             data_clk,
  input  logic                                             data_reset,
  input  chan_select_pkg::sample_t [`PHYS_CHANNELS-1:0]    in_data,
  input  logic [`PHYS_CHANNELS-1:0]                        in_valid,
  input  logic [1:0]                                       diff_shift,
  output chan_select_pkg::sample_t [`PHYS_CHANNELS-1:0]    diff_data,
  output logic [`PHYS_CHANNELS-1:0]                        diff_valid
);

  import chan_select_pkg::*;

  // one extra bit for the difference, three more for the shift
  localparam int DW = `SAMPLE_WIDTH + 1;
  localparam int SW = `SAMPLE_WIDTH + 4;
  localparam logic signed [SW-1:0] SAT_MAX = SW'(2**(`SAMPLE_WIDTH-1) - 1);
  localparam logic signed [SW-1:0] SAT_MIN = -SW'(2**(`SAMPLE_WIDTH-1));

  sample_t                prev_sample [`PHYS_CHANNELS];
  logic signed [DW-1:0]   diff_wide   [`PHYS_CHANNELS];
  logic signed [SW-1:0]   diff_shl    [`PHYS_CHANNELS];
  sample_t                diff_next   [`PHYS_CHANNELS];

  always_comb begin
    for (int ch = 0; ch < `PHYS_CHANNELS; ch++) begin
      diff_wide[ch] = DW'($signed(in_data[ch])) - DW'($signed(prev_sample[ch]));
      diff_shl[ch]  = SW'(diff_wide[ch]) <<< diff_shift;
      // clamp to the signed sample range
      if (diff_shl[ch] > SAT_MAX) begin
        diff_next[ch] = sample_t'(SAT_MAX);
      end else if (diff_shl[ch] < SAT_MIN) begin
        diff_next[ch] = sample_t'(SAT_MIN);
      end else begin
        diff_next[ch] = sample_t'(diff_shl[ch]);
      end
    end
  end

  // history and valid, history only moves on a valid sample
  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      diff_valid <= '0;
      for (int ch = 0; ch < `PHYS_CHANNELS; ch++) begin
        prev_sample[ch] <= '0;
      end
    end else begin
      diff_valid <= in_valid;
      for (int ch = 0; ch < `PHYS_CHANNELS; ch++) begin
        if (in_valid[ch]) begin
          prev_sample[ch] <= in_data[ch];
        end
      end
    end
  end

  // output data, don't care when valid is low
  always_ff @(posedge data_clk) begin
    for (int ch = 0; ch < `PHYS_CHANNELS; ch++) begin
      if (in_valid[ch]) begin
        diff_data[ch] <= diff_next[ch];
      end
    end
  end

endmodule

// File: verilog/boxcar_filter.sv
/*
 * boxcar averaging filter
 * 2-tap or 4-tap running mean per channel, divided by arithmetic
 * shift so results round toward minus infinity
 */
`include "chan_select_cfg.svh"

module boxcar_filter (
  input  logic                                             data_clk,
  input  logic                                             data_reset,
  input  chan_select_pkg::sample_t [`PHYS_CHANNELS-1:0]    in_data,
  input  logic [`PHYS_CHANNELS-1:0]                        in_valid,
  input  logic                                             avg_four_tap,
  output chan_select_pkg::sample_t [`PHYS_CHANNELS-1:0]    avg_data,
  output logic [`PHYS_CHANNELS-1:0]                        avg_valid
);

  import chan_select_pkg::*;

  // sum widths, one growth bit for two terms, two for four
  localparam int W2 = `SAMPLE_WIDTH + 1;
  localparam int W4 = `SAMPLE_WIDTH + 2;
  localparam int HIST_DEPTH = 3;

  // hist[ch][0] is the most recent valid sample
  sample_t              hist     [`PHYS_CHANNELS][HIST_DEPTH];
  logic signed [W2-1:0] sum_two  [`PHYS_CHANNELS];
  logic signed [W4-1:0] sum_four [`PHYS_CHANNELS];
  sample_t              avg_next [`PHYS_CHANNELS];

  always_comb begin
    for (int ch = 0; ch < `PHYS_CHANNELS; ch++) begin
      sum_two[ch]  = W2'($signed(in_data[ch])) + W2'(hist[ch][0]);
      sum_four[ch] = W4'($signed(in_data[ch])) + W4'(hist[ch][0])
                   + W4'(hist[ch][1]) + W4'(hist[ch][2]);
      // both quotients fit back into one sample
      if (avg_four_tap) begin
        avg_next[ch] = sample_t'(sum_four[ch] >>> 2);
      end else begin
        avg_next[ch] = sample_t'(sum_two[ch] >>> 1);
      end
    end
  end

  // history shift register, advances only on a valid sample
  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      avg_valid <= '0;
      for (int ch = 0; ch < `PHYS_CHANNELS; ch++) begin
        for (int t = 0; t < HIST_DEPTH; t++) begin
          hist[ch][t] <= '0;
        end
      end
    end else begin
      avg_valid <= in_valid;
      for (int ch = 0; ch < `PHYS_CHANNELS; ch++) begin
        if (in_valid[ch]) begin
          hist[ch][0] <= in_data[ch];
          for (int t = 1; t < HIST_DEPTH; t++) begin
            hist[ch][t] <= hist[ch][t-1];
          end
        end
      end
    end
  end

  // averaged output
  always_ff @(posedge data_clk) begin
    for (int ch = 0; ch < `PHYS_CHANNELS; ch++) begin
      if (in_valid[ch]) begin
        avg_data[ch] <= avg_next[ch];
      end
    end
  end

endmodule

// File: verilog/channel_mux.sv
/*
 * registered source multiplexer
 * routes any of the raw, derivative or averaged streams to each
 * output, raw path delayed one stage to line up with the derived ones
 */
`include "chan_select_cfg.svh"

module channel_mux (
  input  logic                                             data_clk,
  input  logic                                             data_reset,
  input  chan_select_pkg::sample_t [`PHYS_CHANNELS-1:0]    raw_data,
  input  logic [`PHYS_CHANNELS-1:0]                        raw_valid,
  input  chan_select_pkg::sample_t [`PHYS_CHANNELS-1:0]    diff_data,
  input  logic [`PHYS_CHANNELS-1:0]                        diff_valid,
  input  chan_select_pkg::sample_t [`PHYS_CHANNELS-1:0]    avg_data,
  input  logic [`PHYS_CHANNELS-1:0]                        avg_valid,
  input  chan_select_pkg::source_sel_t [`OUT_CHANNELS-1:0] select_map,
  output chan_select_pkg::sample_t [`OUT_CHANNELS-1:0]     out_data,
  output logic [`OUT_CHANNELS-1:0]                         out_valid
);

  import chan_select_pkg::*;

  // every index the select field can name, top ones tied off
  localparam int SEL_SPAN = 2**$bits(source_sel_t);

  sample_t [`PHYS_CHANNELS-1:0] raw_data_q;
  logic [`PHYS_CHANNELS-1:0]    raw_valid_q;
  sample_t [SEL_SPAN-1:0]       src_data;
  logic [SEL_SPAN-1:0]          src_valid;

  // align raw with the one-cycle derived blocks
  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      raw_valid_q <= '0;
    end else begin
      raw_valid_q <= raw_valid;
    end
  end

  always_ff @(posedge data_clk) begin
    raw_data_q <= raw_data;
  end

  // flatten the three groups into one source table
  always_comb begin
    for (int i = `SOURCE_COUNT; i < SEL_SPAN; i++) begin
      src_data[i]  = '0;
      src_valid[i] = 1'b0;
    end
    for (int ch = 0; ch < `PHYS_CHANNELS; ch++) begin
      src_data[ch]                     = raw_data_q[ch];
      src_valid[ch]                    = raw_valid_q[ch];
      src_data[`PHYS_CHANNELS + ch]    = diff_data[ch];
      src_valid[`PHYS_CHANNELS + ch]   = diff_valid[ch];
      src_data[2*`PHYS_CHANNELS + ch]  = avg_data[ch];
      src_valid[2*`PHYS_CHANNELS + ch] = avg_valid[ch];
    end
  end

  // output stage, only valid is cleared
  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      out_valid <= '0;
    end else begin
      for (int k = 0; k < `OUT_CHANNELS; k++) begin
        out_valid[k] <= src_valid[select_map[k]];
      end
    end
  end

  always_ff @(posedge data_clk) begin
    for (int k = 0; k < `OUT_CHANNELS; k++) begin
      out_data[k] <= src_data[select_map[k]];
    end
  end

endmodule

// File: verilog/adc_chan_select_top.sv
/*
 * ADC channel selector top level
 * register block, derivative and boxcar stages feeding the
 * output multiplexer, two cycles from sample in to sample out
 */
`include "chan_select_cfg.svh"

module adc_chan_select_top (
  input  logic                                             data_clk,
  input  logic                                             data_reset,
  input  chan_select_pkg::sample_t [`PHYS_CHANNELS-1:0]    adc_data,
  input  logic [`PHYS_CHANNELS-1:0]                        adc_valid,
  input  logic                                             wb_cyc,
  input  logic                                             wb_stb,
  input  logic                                             wb_we,
  input  logic                                             wb_adr,
  input  logic [`WB_DATA_WIDTH-1:0]                        wb_dat_w,
  output logic [`WB_DATA_WIDTH-1:0]                        wb_dat_r,
  output logic                                             wb_ack,
  output chan_select_pkg::sample_t [`OUT_CHANNELS-1:0]     out_data,
  output logic [`OUT_CHANNELS-1:0]                         out_valid
);

  import chan_select_pkg::*;

  source_sel_t [`OUT_CHANNELS-1:0] select_map;
  logic [1:0]                      diff_shift;
  logic                            avg_four_tap;
  sample_t [`PHYS_CHANNELS-1:0]    diff_data;
  logic [`PHYS_CHANNELS-1:0]       diff_valid;
  sample_t [`PHYS_CHANNELS-1:0]    avg_data;
  logic [`PHYS_CHANNELS-1:0]       avg_valid;

  // configuration
  wb_select_regs regs_i (
    .data_clk     (data_clk),
    .data_reset   (data_reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .select_map   (select_map),
    .diff_shift   (diff_shift),
    .avg_four_tap (avg_four_tap)
  );

  // derived quantities, side by side
  finite_diff diff_i (
    .data_clk   (data_clk),
    .data_reset (data_reset),
    .in_data    (adc_data),
    .in_valid   (adc_valid),
    .diff_shift (diff_shift),
    .diff_data  (diff_data),
    .diff_valid (diff_valid)
  );

  boxcar_filter avg_i (
    .data_clk     (data_clk),
    .data_reset   (data_reset),
    .in_data      (adc_data),
    .in_valid     (adc_valid),
    .avg_four_tap (avg_four_tap),
    .avg_data     (avg_data),
    .avg_valid    (avg_valid)
  );

  // output selection
  channel_mux mux_i (
    .data_clk   (data_clk),
    .data_reset (data_reset),
    .raw_data   (adc_data),
    .raw_valid  (adc_valid),
    .diff_data  (diff_data),
    .diff_valid (diff_valid),
    .avg_data   (avg_data),
    .avg_valid  (avg_valid),
    .select_map (select_map),
    .out_data   (out_data),
    .out_valid  (out_valid)
  );

endmodule

// File: dv/chan_select_tb.sv
/*
 * ADC channel selector testbench
 * table-driven samples and Wishbone configuration, with a reference
 * model of the raw, derivative and boxcar paths checked at the outputs
 */
`include "chan_select_cfg.svh"

module chan_select_tb;

  import chan_select_pkg::*;

  localparam int SW         = `SAMPLE_WIDTH;
  localparam int IN_BITS    = `PHYS_CHANNELS * SW;
  localparam int OUT_BITS   = `OUT_CHANNELS * SW;
  localparam int SAT_MAX    = 2**(SW-1) - 1;
  localparam int SAT_MIN    = -(2**(SW-1));
  localparam int PIPE_DEPTH = 2;
  localparam int WB_TIMEOUT = 20;

  // one table row, config writes go out before the samples
  typedef struct packed {
    logic                      do_sel;
    logic [`WB_DATA_WIDTH-1:0] sel_word;
    logic                      do_ctrl;
    logic [`WB_DATA_WIDTH-1:0] ctrl_word;
    logic [IN_BITS-1:0]        samples;
    logic [`PHYS_CHANNELS-1:0] mask;
  } row_t;

  logic                         data_clk;
  logic                         data_reset;
  sample_t [`PHYS_CHANNELS-1:0] adc_data;
  logic [`PHYS_CHANNELS-1:0]    adc_valid;
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic                         wb_adr;
  logic [`WB_DATA_WIDTH-1:0]    wb_dat_w;
  logic [`WB_DATA_WIDTH-1:0]    wb_dat_r;
  logic                         wb_ack;
  sample_t [`OUT_CHANNELS-1:0]  out_data;
  logic [`OUT_CHANNELS-1:0]     out_valid;

  row_t                     stim_q [$];
  // expected outputs, one entry per driven cycle
  logic [OUT_BITS-1:0]      exp_data_q [$];
  logic [`OUT_CHANNELS-1:0] exp_valid_q [$];

  // model state, previous samples and the current settings
  int          prev_sample [`PHYS_CHANNELS];
  int          hist [`PHYS_CHANNELS][3];
  logic [3:0]  model_sel [`OUT_CHANNELS];
  int          model_shift;
  logic        model_four_tap;

  adc_chan_select_top dut (
    .data_clk   (data_clk),
    .data_reset (data_reset),
    .adc_data   (adc_data),
    .adc_valid  (adc_valid),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .out_data   (out_data),
    .out_valid  (out_valid)
  );

  initial data_clk = 1'b0;
  always #10 data_clk = ~data_clk;

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopping the run");
  endtask

  function automatic int saturate(input int value);
    if (value > SAT_MAX) begin
      return SAT_MAX;
    end else if (value < SAT_MIN) begin
      return SAT_MIN;
    end
    return value;
  endfunction

  // channel 0 in the low bits
  function automatic logic [IN_BITS-1:0] pack4(input int s0, input int s1,
                                                input int s2, input int s3);
    return {SW'(s3), SW'(s2), SW'(s1), SW'(s0)};
  endfunction

  function automatic logic [IN_BITS-1:0] random_samples();
    return pack4($urandom(), $urandom(), $urandom(), $urandom());
  endfunction

  // expected outputs for one driven row, then advance the history
  task automatic model_row(input logic [IN_BITS-1:0] samples,
                           input logic [`PHYS_CHANNELS-1:0] mask);
    int                       src_val [16];
    logic                     src_ok [16];
    int                       s;
    int                       idx;
    logic [OUT_BITS-1:0]      exp_data;
    logic [`OUT_CHANNELS-1:0] exp_valid;
    for (int i = 0; i < 16; i++) begin
      src_val[i] = 0;
      src_ok[i]  = 1'b0;
    end
    for (int ch = 0; ch < `PHYS_CHANNELS; ch++) begin
      s = int'($signed(samples[ch*SW +: SW]));
      src_val[ch] = s;
      // difference scaled by 2**shift, then clamped
      src_val[4 + ch] = saturate((s - prev_sample[ch]) * (1 << model_shift));
      // floor division by an arithmetic shift
      if (model_four_tap) begin
        src_val[8 + ch] = (s + hist[ch][0] + hist[ch][1] + hist[ch][2]) >>> 2;
      end else begin
        src_val[8 + ch] = (s + hist[ch][0]) >>> 1;
      end
      src_ok[ch]     = mask[ch];
      src_ok[4 + ch] = mask[ch];
      src_ok[8 + ch] = mask[ch];
      if (mask[ch]) begin
        prev_sample[ch] = s;
        hist[ch][2]     = hist[ch][1];
        hist[ch][1]     = hist[ch][0];
        hist[ch][0]     = s;
      end
    end
    for (int k = 0; k < `OUT_CHANNELS; k++) begin
      idx = int'(model_sel[k]);
      exp_valid[k]            = src_ok[idx];
      exp_data[k*SW +: SW]    = SW'(src_val[idx]);
    end
    exp_data_q.push_back(exp_data);
    exp_valid_q.push_back(exp_valid);
  endtask

  task automatic check_outputs();
    logic [OUT_BITS-1:0]      exp_data;
    logic [`OUT_CHANNELS-1:0] exp_valid;
    exp_data  = exp_data_q.pop_front();
    exp_valid = exp_valid_q.pop_front();
    assert (out_valid === exp_valid) else begin
      report_mismatch($sformatf("out_valid %b, expected %b", out_valid, exp_valid));
    end
    for (int k = 0; k < `OUT_CHANNELS; k++) begin
      // data is only meaningful with valid high
      if (exp_valid[k]) begin
        assert (out_data[k] === exp_data[k*SW +: SW]) else begin
          report_mismatch($sformatf("out_data[%0d] %0d, expected %0d", k,
                                    out_data[k], $signed(exp_data[k*SW +: SW])));
        end
      end
    end
  endtask

  // one cycle: check the row from two cycles back, then drive the next
  task automatic step(input logic [IN_BITS-1:0] samples,
                      input logic [`PHYS_CHANNELS-1:0] mask);
    @(negedge data_clk);
    if (exp_valid_q.size() == PIPE_DEPTH) begin
      check_outputs();
    end
    adc_data  = samples;
    adc_valid = mask;
    model_row(samples, mask);
  endtask

  task automatic wait_ack(input logic adr);
    int cycles;
    cycles = 0;
    while (1) begin
      step('0, '0);
      cycles++;
      if (wb_ack) begin
        break;
      end
      if (cycles >= WB_TIMEOUT) begin
        abort_run($sformatf("no Wishbone ack within %0d cycles at address %0d",
                            WB_TIMEOUT, adr));
      end
    end
  endtask

  task automatic wb_write(input logic adr, input logic [`WB_DATA_WIDTH-1:0] data);
    // idle cycle so the last row passes the mux stage on the old map
    step('0, '0);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_ack(adr);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // rows driven from here on see the new setting
    if (adr == 1'b0) begin
      for (int k = 0; k < `OUT_CHANNELS; k++) begin
        model_sel[k] = data[4*k +: 4];
      end
    end else begin
      model_shift    = int'(data[1:0]);
      model_four_tap = data[2];
    end
  endtask

  task automatic wb_read(input logic adr, output logic [`WB_DATA_WIDTH-1:0] data);
    step('0, '0);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack(adr);
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // write, then read back with the padding bits cleared
  task automatic write_and_verify(input logic adr, input logic [`WB_DATA_WIDTH-1:0] data);
    logic [`WB_DATA_WIDTH-1:0] rd;
    logic [`WB_DATA_WIDTH-1:0] expect_rd;
    wb_write(adr, data);
    wb_read(adr, rd);
    if (adr == 1'b0) begin
      expect_rd = {16'h0, data[15:0]};
    end else begin
      expect_rd = {29'h0, data[2:0]};
    end
    assert (rd === expect_rd) else begin
      report_mismatch($sformatf("readback at %0d is %h, expected %h", adr, rd, expect_rd));
    end
  endtask

  task automatic add_row(input logic do_sel, input logic [`WB_DATA_WIDTH-1:0] sel_word,
                         input logic do_ctrl, input logic [`WB_DATA_WIDTH-1:0] ctrl_word,
                         input logic [IN_BITS-1:0] samples,
                         input logic [`PHYS_CHANNELS-1:0] mask);
    row_t r;
    r.do_sel    = do_sel;
    r.sel_word  = sel_word;
    r.do_ctrl   = do_ctrl;
    r.ctrl_word = ctrl_word;
    r.samples   = samples;
    r.mask      = mask;
    stim_q.push_back(r);
  endtask

  task automatic add_random_rows(input int n, input logic random_mask);
    for (int i = 0; i < n; i++) begin
      add_row(1'b0, '0, 1'b0, '0, random_samples(),
              random_mask ? 4'($urandom()) : 4'hF);
    end
  endtask

  task automatic build_table();
    // identity map straight out of reset
    add_row(1'b0, '0, 1'b0, '0, pack4(100, -200, 300, -400), 4'hF);
    add_row(1'b0, '0, 1'b0, '0, pack4(32767, -32768, 0, 1), 4'hF);
    add_row(1'b0, '0, 1'b0, '0, pack4(5, 6, 7, 8), 4'b0101);
    add_row(1'b0, '0, 1'b0, '0, pack4(-1, -2, -3, -4), 4'hF);
    // raw ch2, diff ch1, avg ch3, tied-off 13, junk in the padding
    add_row(1'b1, 32'hA5A5_DB52, 1'b0, '0, pack4(10, 20, 30, 40), 4'hF);
    add_row(1'b0, '0, 1'b0, '0, pack4(11, -25, 33, 47), 4'hF);
    add_row(1'b0, '0, 1'b0, '0, pack4(-900, 400, 12, -7), 4'b1010);
    add_random_rows(4, 1'b0);
    // all outputs on derivatives, shift 0 to 3 with large random steps
    for (int sh = 0; sh < 4; sh++) begin
      add_row(sh == 0, 32'h1234_7654, 1'b1, 32'hDEAD_BEE0 | 32'(sh),
              pack4(-30000, 30000, 12, -12), 4'hF);
      add_random_rows(6, 1'b0);
    end
    // averages, 2-tap first, odd negative sums check the rounding
    add_row(1'b1, 32'h0000_BA98, 1'b1, 32'hFFFF_FFF8, pack4(-3, -1, 3, -32768), 4'hF);
    add_row(1'b0, '0, 1'b0, '0, pack4(-4, 2, -6, -32768), 4'hF);
    add_random_rows(4, 1'b0);
    add_row(1'b0, '0, 1'b1, 32'hFFFF_FFFC, pack4(7, -9, 32767, -1), 4'hF);
    add_row(1'b0, '0, 1'b0, '0, pack4(-5, 13, 32767, -2), 4'hF);
    add_random_rows(5, 1'b0);
    // valid gaps, diff and avg of ch0 and ch1 side by side
    add_row(1'b1, 32'h0000_9584, 1'b1, 32'h0000_0005, pack4(1000, 2000, 0, 0), 4'b0011);
    add_row(1'b0, '0, 1'b0, '0, pack4(-7000, 9, 0, 0), 4'b0010);
    add_row(1'b0, '0, 1'b0, '0, pack4(3000, 777, 0, 0), 4'b0001);
    add_row(1'b0, '0, 1'b0, '0, pack4(-1234, 4321, 0, 0), 4'b0000);
    add_row(1'b0, '0, 1'b0, '0, pack4(-1500, -9000, 0, 0), 4'b0011);
    add_random_rows(8, 1'b1);
    // back to identity with random masks
    add_row(1'b1, 32'h0000_3210, 1'b1, 32'h0000_0000, random_samples(), 4'hF);
    add_random_rows(8, 1'b1);
  endtask

  initial begin
    row_t r;
    void'($urandom(7));
    data_reset = 1'b1;
    adc_data   = '0;
    adc_valid  = '0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = 1'b0;
    wb_dat_w   = '0;
    // model reset state, identity map and zero history
    for (int ch = 0; ch < `PHYS_CHANNELS; ch++) begin
      prev_sample[ch] = 0;
      for (int t = 0; t < 3; t++) begin
        hist[ch][t] = 0;
      end
    end
    for (int k = 0; k < `OUT_CHANNELS; k++) begin
      model_sel[k] = 4'(k);
    end
    model_shift    = 0;
    model_four_tap = 1'b0;
    build_table();
    repeat (3) @(negedge data_clk);
    data_reset = 1'b0;
    foreach (stim_q[i]) begin
      r = stim_q[i];
      if (r.do_sel) begin
        write_and_verify(1'b0, r.sel_word);
      end
      if (r.do_ctrl) begin
        write_and_verify(1'b1, r.ctrl_word);
      end
      step(r.samples, r.mask);
    end
    // drain the last rows through the pipeline
    repeat (PIPE_DEPTH) step('0, '0);
    $display("Regression passed");
    $finish;
  end

endmodule

// File: src.f
+incdir+include
verilog/chan_select_pkg.sv
verilog/wb_select_regs.sv
verilog/finite_diff.sv
verilog/boxcar_filter.sv
verilog/channel_mux.sv
verilog/adc_chan_select_top.sv
dv/chan_select_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the channel selector regression with Verilator
# exit status is the simulator's, non-zero on any failing check

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f src.f \
  --top-module chan_select_tb \
  -o chan_select_sim

./obj_dir/chan_select_sim
